// File: files.f
rtl/gpio_pkg.sv
rtl/gpio_input_sync.sv
rtl/gpio_reg_bank.sv
rtl/gpio_out_stage.sv
rtl/gpio_top.sv
testbench/gpio_tb.sv

// File: rtl/gpio_input_sync.sv
//////////////////////////////////////////////////////////////////////
// GPIO input synchronizer
// flip-flop chain for async pins and rising edge detection
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module gpio_input_sync #(
  parameter int unsigned GW      = 32,  // pin count
  parameter int unsigned CFG_CDC = 2    // synchronizer depth
)(
  input  logic          tcb,
  input  logic          rst_n,
  input  logic [GW-1:0] gpio_i,
  output logic [GW-1:0] pin_sync,
  output logic [GW-1:0] pin_rise
);

  // synchronizer stages with index 0 at the pins
  logic [CFG_CDC-1:0][GW-1:0] sync_q;
  // previous synchronized value
  logic [GW-1:0]              last_q;

  //////////////////////////////////////////////////////////////////////
  // synchronizer chain
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= '0;
      last_q <= '0;
    end else begin
      sync_q[0] <= gpio_i;
      // shift towards the last stage
      for (int i = 1; i < CFG_CDC; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
      last_q <= sync_q[CFG_CDC-1];
    end
  end

  // last stage is the stable pin value
  assign pin_sync = sync_q[CFG_CDC-1];

  // high now and low one cycle ago
  assign pin_rise = pin_sync & ~last_q;

  // a flagged pin is high now and was high at the input CFG_CDC cycles back
  assert property (@(posedge tcb) disable iff (!rst_n)
    (pin_rise & ~(pin_sync & $past(gpio_i, CFG_CDC))) == '0)
    else $error("pin_rise set on a pin that did not rise through the chain");

endmodule : gpio_input_sync

`default_nettype wire

// File: rtl/gpio_out_stage.sv
//////////////////////////////////////////////////////////////////////
// GPIO output stage
// response register with a one-cycle strobe and registered irq
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module gpio_out_stage #(
  parameter int unsigned GW = 32  // pin count
)(
  input  logic                tcb,
  input  logic                rst_n,
  // from the register bank
  input  logic                rsp_take,
  input  gpio_pkg::gpio_rsp_t rsp_next,
  input  logic [GW-1:0]       irq_pend,
  // response towards the manager
  output logic                rsp_vld,
  output gpio_pkg::gpio_rsp_t rsp,
  // level interrupt
  output logic                irq
);

  //////////////////////////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////////////////////////

  // strobe, one cycle per accepted request
  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      rsp_vld <= 1'b0;
    end else begin
      rsp_vld <= rsp_take;
    end
  end

  // payload only loads with a request, holds otherwise
  always_ff @(posedge tcb) begin
    if (rsp_take) begin
      rsp <= rsp_next;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // interrupt
  //////////////////////////////////////////////////////////////////////

  // any masked edge raises the line
  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      irq <= 1'b0;
    end else begin
      irq <= |irq_pend;
    end
  end

  // no response without a request one cycle earlier
  assert property (@(posedge tcb) disable iff (!rst_n)
    rsp_vld |-> $past(rsp_take))
    else $error("rsp_vld without a preceding request");

endmodule : gpio_out_stage

`default_nettype wire

// File: rtl/gpio_pkg.sv
//////////////////////////////////////////////////////////////////////
// GPIO peripheral shared definitions
// bus word and address types, register offsets, request/response
//////////////////////////////////////////////////////////////////////

`default_nettype none

package gpio_pkg;

  //////////////////////////////////////////////////////////////////////
  // bus widths
  //////////////////////////////////////////////////////////////////////

  // data bus word
  typedef logic [32-1:0] data_t;

  // byte address of a register
  typedef logic [8-1:0] adr_t;

  //////////////////////////////////////////////////////////////////////
  // register map
  //////////////////////////////////////////////////////////////////////

  // output value, read/write
  localparam adr_t ADR_OUT  = 8'h00;
  // output enable, read/write
  localparam adr_t ADR_OE   = 8'h04;
  // synchronized input, read only
  localparam adr_t ADR_IN   = 8'h08;
  // rising edge status, write one to clear
  localparam adr_t ADR_EDGE = 8'h0C;
  // interrupt mask, read/write
  localparam adr_t ADR_MASK = 8'h10;

  //////////////////////////////////////////////////////////////////////
  // request and response
  //////////////////////////////////////////////////////////////////////

  // request, qualified by req_vld
  typedef struct packed {
    logic  wen;  // write enable
    adr_t  adr;  // register byte address
    data_t wdt;  // write data
  } gpio_req_t;

  // response, qualified by rsp_vld
  typedef struct packed {
    data_t rdt;  // read data
    logic  sts;  // set on unmapped address
  } gpio_rsp_t;

endpackage : gpio_pkg

`default_nettype wire

// File: rtl/gpio_reg_bank.sv
//////////////////////////////////////////////////////////////////////
// GPIO register bank
// address decode, out/oe/edge/mask registers, read data and status
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module gpio_reg_bank #(
  parameter int unsigned GW = 32  // pin count
)(
  input  logic                tcb,
  input  logic                rst_n,
  // request
  input  logic                req_vld,
  input  gpio_pkg::gpio_req_t req,
  // synchronized pins
  input  logic [GW-1:0]       pin_sync,
  input  logic [GW-1:0]       pin_rise,
  // pin drivers
  output logic [GW-1:0]       gpio_o,
  output logic [GW-1:0]       gpio_e,
  // towards the output stage
  output gpio_pkg::gpio_rsp_t rsp_next,
  output logic                rsp_take,
  output logic [GW-1:0]       irq_pend
);

  // data bits above the pin count
  localparam gpio_pkg::data_t HI_MASK = ~gpio_pkg::data_t'({GW{1'b1}});

  // one-hot register select
  logic sel_out;
  logic sel_oe;
  logic sel_in;
  logic sel_edge;
  logic sel_mask;
  logic sel_err;

  // qualified accesses
  logic wr;
  logic rd;

  // edge status and mask
  logic [GW-1:0] edge_q;
  logic [GW-1:0] mask_q;

  // bits to clear in the edge status
  logic [GW-1:0] edge_clr;

  // read data before the response register
  gpio_pkg::data_t rdt;

  //////////////////////////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////////////////////////

  // shared by reads and writes
  always_comb begin
    sel_out  = 1'b0;
    sel_oe   = 1'b0;
    sel_in   = 1'b0;
    sel_edge = 1'b0;
    sel_mask = 1'b0;
    sel_err  = 1'b0;
    case (req.adr)
      gpio_pkg::ADR_OUT:  sel_out  = 1'b1;
      gpio_pkg::ADR_OE:   sel_oe   = 1'b1;
      gpio_pkg::ADR_IN:   sel_in   = 1'b1;
      gpio_pkg::ADR_EDGE: sel_edge = 1'b1;
      gpio_pkg::ADR_MASK: sel_mask = 1'b1;
      default:            sel_err  = 1'b1;
    endcase
  end

  assign wr = req_vld &  req.wen;
  assign rd = req_vld & ~req.wen;

  //////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////

  // write ones to clear, only on an edge write
  assign edge_clr = (wr && sel_edge) ? req.wdt[GW-1:0] : '0;

  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      gpio_o <= '0;
      gpio_e <= '0;
      edge_q <= '0;
      mask_q <= '0;
    end else begin
      if (wr && sel_out) begin
        gpio_o <= req.wdt[GW-1:0];
      end
      if (wr && sel_oe) begin
        gpio_e <= req.wdt[GW-1:0];
      end
      if (wr && sel_mask) begin
        mask_q <= req.wdt[GW-1:0];
      end
      // new edge wins over a clear in the same cycle
      edge_q <= (edge_q & ~edge_clr) | pin_rise;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read data and status
  //////////////////////////////////////////////////////////////////////

  // upper bits stay zero
  always_comb begin
    rdt = '0;
    if (sel_out) begin
      rdt[GW-1:0] = gpio_o;
    end else if (sel_oe) begin
      rdt[GW-1:0] = gpio_e;
    end else if (sel_in) begin
      rdt[GW-1:0] = pin_sync;
    end else if (sel_edge) begin
      rdt[GW-1:0] = edge_q;
    end else if (sel_mask) begin
      rdt[GW-1:0] = mask_q;
    end
  end

  // unmapped address flags an error, reads and writes alike
  assign rsp_next.rdt = rdt;
  assign rsp_next.sts = sel_err;

  // every valid request gets a response
  assign rsp_take = req_vld;

  // masked pending edges
  assign irq_pend = edge_q & mask_q;

  // OUT written then read back holds only the low GW bits
  assert property (@(posedge tcb) disable iff (!rst_n)
    (wr && sel_out) ##1 (rd && sel_out) |-> (rdt == ($past(req.wdt) & ~HI_MASK)))
    else $error("OUT readback differs from written value");

  // same for OE
  assert property (@(posedge tcb) disable iff (!rst_n)
    (wr && sel_oe) ##1 (rd && sel_oe) |-> (rdt == ($past(req.wdt) & ~HI_MASK)))
    else $error("OE readback differs from written value");

endmodule : gpio_reg_bank

`default_nettype wire

// File: rtl/gpio_top.sv
//////////////////////////////////////////////////////////////////////
// GPIO peripheral top level
// input synchronizer, register bank and response stage
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module gpio_top #(
  parameter int unsigned GW      = 32,  // pin count, 1 to 32
  parameter int unsigned CFG_CDC = 2    // synchronizer depth, 1 to 4
)(
  input  logic                tcb,
  input  logic                rst_n,
  // request
  input  logic                req_vld,
  input  gpio_pkg::gpio_req_t req,
  // response
  output logic                rsp_vld,
  output gpio_pkg::gpio_rsp_t rsp,
  // pins
  input  logic [GW-1:0]       gpio_i,
  output logic [GW-1:0]       gpio_o,
  output logic [GW-1:0]       gpio_e,
  // interrupt
  output logic                irq
);

  // parameter range
  if ((GW < 1) || (GW > 32)) begin : gen_gw_check
    $error("GW out of range 1 to 32");
  end
  if ((CFG_CDC < 1) || (CFG_CDC > 4)) begin : gen_cdc_check
    $error("CFG_CDC out of range 1 to 4");
  end

  // synchronized pins and edges
  logic [GW-1:0]       pin_sync;
  logic [GW-1:0]       pin_rise;
  // response before the register
  gpio_pkg::gpio_rsp_t rsp_next;
  logic                rsp_take;
  // masked edges
  logic [GW-1:0]       irq_pend;

  gpio_input_sync #(
    .GW      (GW),
    .CFG_CDC (CFG_CDC)
  ) u_input_sync (
    .tcb      (tcb),
    .rst_n    (rst_n),
    .gpio_i   (gpio_i),
    .pin_sync (pin_sync),
    .pin_rise (pin_rise)
  );

  gpio_reg_bank #(
    .GW (GW)
  ) u_reg_bank (
    .tcb      (tcb),
    .rst_n    (rst_n),
    .req_vld  (req_vld),
    .req      (req),
    .pin_sync (pin_sync),
    .pin_rise (pin_rise),
    .gpio_o   (gpio_o),
    .gpio_e   (gpio_e),
    .rsp_next (rsp_next),
    .rsp_take (rsp_take),
    .irq_pend (irq_pend)
  );

  gpio_out_stage #(
    .GW (GW)
  ) u_out_stage (
    .tcb      (tcb),
    .rst_n    (rst_n),
    .rsp_take (rsp_take),
    .rsp_next (rsp_next),
    .irq_pend (irq_pend),
    .rsp_vld  (rsp_vld),
    .rsp      (rsp),
    .irq      (irq)
  );

endmodule : gpio_top

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build and run the GPIO testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 --top-module gpio_tb -f files.f \
  && ./obj_dir/Vgpio_tb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// File: testbench/gpio_cases.txt
# op adr data expected, all hex
# W write, R read, P set pins (adr 01 random), C check irq
R 00 00000000 00000000
R 04 00000000 00000000
R 0C 00000000 00000000
R 10 00000000 00000000
C 00 00000000 00000000
W 00 1234a5c3 0000a5c3
R 00 00000000 0000a5c3
W 04 ffffffff 0000ffff
R 04 00000000 0000ffff
P 00 00005a0f 00000000
R 08 00000000 00005a0f
W 08 ffffffff 00000000
R 08 00000000 00005a0f
R 0C 00000000 00005a0f
W 10 0000000f 00000000
C 00 00000000 00000001
W 0C 0000000f 00000000
R 0C 00000000 00005a00
C 00 00000000 00000000
W 10 0000ff00 00000000
C 00 00000000 00000001
W 10 00000000 00000000
C 00 00000000 00000000
P 00 00000000 00000000
R 0C 00000000 00005a00
R 20 00000000 00000000
W 14 ffffffff 00000000
R 00 00000000 0000a5c3
R 04 00000000 0000ffff
R 10 00000000 00000000
R 0C 00000000 00005a00
W 0C ffffffff 00000000
R 0C 00000000 00000000
P 01 00000000 00000000
W 0C ffffffff 00000000
R 0C 00000000 00000000
P 00 00000000 00000000
R 08 00000000 00000000
R 0C 00000000 00000000

// File: testbench/gpio_tb.sv
//////////////////////////////////////////////////////////////////////
// GPIO peripheral testbench
// runs register, pin and interrupt cases from a file against the DUT
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module gpio_tb;

  localparam int unsigned GW      = 16;
  localparam int unsigned CFG_CDC = 2;

  logic                tcb;
  logic                rst_n;
  logic                req_vld;
  gpio_pkg::gpio_req_t req;
  logic                rsp_vld;
  gpio_pkg::gpio_rsp_t rsp;
  logic [GW-1:0]       gpio_i;
  logic [GW-1:0]       gpio_o;
  logic [GW-1:0]       gpio_e;
  logic                irq;

  int errors;

  gpio_top #(
    .GW      (GW),
    .CFG_CDC (CFG_CDC)
  ) DUT (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .req_vld (req_vld),
    .req     (req),
    .rsp_vld (rsp_vld),
    .rsp     (rsp),
    .gpio_i  (gpio_i),
    .gpio_o  (gpio_o),
    .gpio_e  (gpio_e),
    .irq     (irq)
  );

  // 40 ns period
  always #20 tcb = ~tcb;

  // step to the drive point 2 ns past the rising edge
  task automatic idle(input int n);
    repeat (n) begin
      @(posedge tcb);
      #2;
    end
  endtask

  // only five word offsets are mapped
  function automatic logic unmapped(input logic [7:0] adr);
    return !(adr inside {8'h00, 8'h04, 8'h08, 8'h0C, 8'h10});
  endfunction

  // one request and a poll for its response
  task automatic do_request(input logic wen, input logic [7:0] adr, input logic [31:0] wdt,
                            output gpio_pkg::gpio_rsp_t got, output logic seen);
    int polls;
    req_vld = 1'b1;
    req.wen = wen;
    req.adr = adr;
    req.wdt = wdt;
    idle(1);
    req_vld = 1'b0;
    seen    = 1'b0;
    got     = '0;
    polls   = 0;
    for (int n = 0; n < 10 && !seen; n++) begin
      if (rsp_vld) begin
        seen = 1'b1;
        got  = rsp;
      end else begin
        polls++;
        idle(1);
      end
    end
    if (!seen) begin
      $display("no response within 10 cycles for a request to address %h", adr);
      errors++;
    end else if (polls != 0) begin
      // response strobe belongs right after the accepting edge
      $display("response to address %h came %0d cycles late", adr, polls);
      errors++;
    end
  endtask

  // one line of the cases file
  task automatic run_case(input logic [7:0] op, input logic [7:0] adr,
                          input logic [31:0] dat, input logic [31:0] exp);
    gpio_pkg::gpio_rsp_t got;
    logic                seen;
    logic [GW-1:0]       pat;
    case (op)
      "W", "R": begin
        do_request(op == "W", adr, dat, got, seen);
        if (seen && got.sts !== unmapped(adr)) begin
          $display("Fail rsp.sts at %h expected %h got %h", adr, unmapped(adr), got.sts);
          errors++;
        end
        if (seen && op == "R" && got.rdt !== exp) begin
          $display("Fail rsp.rdt at %h expected %h got %h", adr, exp, got.rdt);
          errors++;
        end
        // pins follow the write at the accepting edge
        if (op == "W" && adr == 8'h00 && gpio_o !== exp[GW-1:0]) begin
          $display("Fail gpio_o expected %h got %h", exp[GW-1:0], gpio_o);
          errors++;
        end
        if (op == "W" && adr == 8'h04 && gpio_e !== exp[GW-1:0]) begin
          $display("Fail gpio_e expected %h got %h", exp[GW-1:0], gpio_e);
          errors++;
        end
      end
      "P": begin
        // address 01 picks a random pattern
        pat    = (adr == 8'h01) ? GW'($urandom) : dat[GW-1:0];
        gpio_i = pat;
        // settle well past the synchronizer depth
        idle(8);
        if (adr == 8'h01) begin
          do_request(1'b0, 8'h08, '0, got, seen);
          if (seen && got.rdt !== 32'(pat)) begin
            $display("Fail rsp.rdt at 08 expected %h got %h", 32'(pat), got.rdt);
            errors++;
          end
        end
      end
      "C": begin
        // edge status to pending to irq register
        idle(2);
        if (irq !== exp[0]) begin
          $display("Fail irq expected %h got %h", exp[0], irq);
          errors++;
        end
      end
      default: begin
        $display("unknown operation in the cases file");
        errors++;
      end
    endcase
  endtask

  initial begin
    int          fd;
    int          code;
    string       line;
    logic [7:0]  op;
    logic [7:0]  adr;
    logic [31:0] dat;
    logic [31:0] exp;
    tcb     = 1'b0;
    rst_n   = 1'b0;
    req_vld = 1'b0;
    req     = '0;
    gpio_i  = '0;
    errors  = 0;
    void'($urandom(32'h746d8d77));

    repeat (10) @(posedge tcb);
    #2;
    rst_n = 1'b1;

    // pin drivers, response strobe and interrupt idle out of reset
    if (gpio_o !== '0) begin
      $display("Fail gpio_o after reset expected %h got %h", {GW{1'b0}}, gpio_o);
      errors++;
    end
    if (gpio_e !== '0) begin
      $display("Fail gpio_e after reset expected %h got %h", {GW{1'b0}}, gpio_e);
      errors++;
    end
    if (rsp_vld !== 1'b0) begin
      $display("Fail rsp_vld after reset expected %h got %h", 1'b0, rsp_vld);
      errors++;
    end
    if (irq !== 1'b0) begin
      $display("Fail irq after reset expected %h got %h", 1'b0, irq);
      errors++;
    end

    fd = $fopen("testbench/gpio_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open testbench/gpio_cases.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        // comment and blank lines do not scan as four fields
        if (code > 0 && $sscanf(line, "%c %h %h %h", op, adr, dat, exp) == 4) begin
          run_case(op, adr, dat, exp);
        end
      end
      $fclose(fd);
    end

    $display("error count %0d", errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule : gpio_tb

`default_nettype wire
